/* source/mem_arb_pkg.sv */
`default_nettype none

package mem_arb_pkg;

	// Core-side address and store word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// The memory returns a whole 64-bit line per response
	typedef logic [63:0] line_t;

	typedef logic [31:0] pdt_t;
	typedef logic [27:0] mmu_flags_t;
	typedef logic [1:0] mmu_mode_t;
	typedef logic [1:0] order_t;

	// Owner of an outstanding load or fetch
	typedef enum logic {
		SRC_INST = 1'b0,
		SRC_DATA = 1'b1
	} req_src_t;

	// Access size used by every instruction fetch
	localparam order_t FETCH_ORDER = 2'd2;

endpackage

`default_nettype wire

/* source/match_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface match_if
	import mem_arb_pkg::*;
();

	// Push side, driven by the request arbiter
	logic wr_req;
	req_src_t wr_type;
	logic wr_full;

	// Pop side, head of queue seen by the router
	logic rd_req;
	logic rd_valid;
	req_src_t rd_type;

	modport writer (
		output wr_req,
		output wr_type,
		input wr_full
	);

	modport reader (
		output rd_req,
		input rd_valid,
		input rd_type
	);

	modport queue (
		input wr_req,
		input wr_type,
		output wr_full,
		input rd_req,
		output rd_valid,
		output rd_type
	);

endinterface

`default_nettype wire

/* source/req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module req_arbiter
	import mem_arb_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	// Data side request
	input wire data_req,
	input wire order_t data_order,
	input wire data_rw,
	input wire mmu_mode_t data_mmu_mode,
	input wire pdt_t data_pdt,
	input wire addr_t data_addr,
	input wire word_t data_data,
	// Instruction side request
	input wire inst_req,
	input wire mmu_mode_t inst_mmu_mode,
	input wire pdt_t inst_pdt,
	input wire addr_t inst_addr,
	// Locks
	input wire memory_lock,
	output logic data_lock,
	output logic inst_lock,
	// Memory request bus
	output logic memory_req,
	output logic memory_store_ack,
	output mmu_mode_t memory_mmu_mode,
	output pdt_t memory_pdt,
	output order_t memory_order,
	output logic memory_rw,
	output addr_t memory_addr,
	output word_t memory_data,
	// Tag push into the match queue
	match_if.writer match_wr
);

	logic common_lock;
	logic data_sel;
	logic inst_sel;
	logic data_store;

	// Memory stall or no room left to track another response
	assign common_lock = memory_lock || match_wr.wr_full;

	// Data side always wins
	assign data_sel = data_req;
	assign inst_sel = inst_req && !data_req;
	assign data_store = data_sel && data_rw;

	assign data_lock = common_lock || inst_sel;
	assign inst_lock = common_lock || data_sel;

	// Stores are acknowledged directly, so only loads and fetches get a tag
	assign match_wr.wr_req = !common_lock && (inst_sel || (data_sel && !data_rw));
	assign match_wr.wr_type = data_sel ? SRC_DATA : SRC_INST;

	// Request strobe and store flag
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			memory_req <= 1'b0;
			memory_store_ack <= 1'b0;
		end else if (!common_lock) begin
			memory_req <= data_sel || inst_sel;
			memory_store_ack <= data_store;
		end
	end

	// Request payload, held while locked
	always_ff @(posedge iCLOCK) begin
		if (!common_lock) begin
			if (data_sel) begin
				memory_mmu_mode <= data_mmu_mode;
				memory_pdt <= data_pdt;
				memory_order <= data_order;
				memory_rw <= data_rw;
				memory_addr <= data_addr;
				memory_data <= data_data;
			end else if (inst_sel) begin
				// Fetch is always a read of fixed size
				memory_mmu_mode <= inst_mmu_mode;
				memory_pdt <= inst_pdt;
				memory_order <= FETCH_ORDER;
				memory_rw <= 1'b0;
				memory_addr <= inst_addr;
				memory_data <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* source/match_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module match_queue
	import mem_arb_pkg::*;
#(
	parameter int QUEUE_DEPTH = 16,
	parameter int QUEUE_DEPTH_N = 4
) (
	input wire iCLOCK,
	input wire inRESET,
	match_if.queue match_q
);

	// Extra MSB tells a full queue from an empty one
	typedef logic [QUEUE_DEPTH_N:0] ptr_t;
	typedef logic [QUEUE_DEPTH_N-1:0] idx_t;

	req_src_t tag_mem [QUEUE_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	idx_t wr_idx;
	idx_t rd_idx;
	logic empty;
	logic full;
	logic push;
	logic pop;

	assign wr_idx = wr_ptr[QUEUE_DEPTH_N-1:0];
	assign rd_idx = rd_ptr[QUEUE_DEPTH_N-1:0];

	// Same index, wrap bits differ
	assign full = (wr_ptr[QUEUE_DEPTH_N] != rd_ptr[QUEUE_DEPTH_N]) && (wr_idx == rd_idx);
	assign empty = (wr_ptr == rd_ptr);

	assign push = match_q.wr_req && !full;
	assign pop = match_q.rd_req && !empty;

	assign match_q.wr_full = full;

	// Head entry shown whenever something is queued
	assign match_q.rd_valid = !empty;
	assign match_q.rd_type = tag_mem[rd_idx];

	// Pointers
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Tag storage
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			tag_mem[wr_idx] <= match_q.wr_type;
		end
	end

endmodule

`default_nettype wire

/* source/rsp_router.sv */
`timescale 1ns/1ps
`default_nettype none

module rsp_router
	import mem_arb_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	// Memory response bus
	input wire memory_valid,
	input wire memory_store_ack,
	input wire line_t memory_data,
	input wire mmu_flags_t memory_flags,
	// Back-pressure from each side
	input wire inst_busy,
	input wire data_busy,
	// Instruction side response
	output logic inst_rsp_valid,
	output line_t inst_rsp_data,
	output mmu_flags_t inst_rsp_flags,
	// Data side response
	output logic data_rsp_valid,
	output line_t data_rsp_data,
	output mmu_flags_t data_rsp_flags,
	// Head of the match queue
	match_if.reader match_rd
);

	logic load_rsp;
	logic head_data;
	logic inst_hit;
	logic data_hit;
	logic store_hit;
	logic inst_valid_q;
	logic data_valid_q;

	// A load or fetch response belongs to the oldest queued tag
	assign load_rsp = memory_valid && !memory_store_ack && match_rd.rd_valid;
	assign head_data = (match_rd.rd_type == SRC_DATA);

	assign inst_hit = load_rsp && !head_data && !inst_busy;
	assign data_hit = load_rsp && head_data && !data_busy;

	// Store acks bypass the queue
	assign store_hit = memory_valid && memory_store_ack && !data_busy;

	// Pop only when the owner can take it
	assign match_rd.rd_req = inst_hit || data_hit;

	// Valid flags hold while the side is busy
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inst_valid_q <= 1'b0;
			data_valid_q <= 1'b0;
		end else begin
			if (!inst_busy) begin
				inst_valid_q <= inst_hit;
			end
			if (!data_busy) begin
				data_valid_q <= data_hit || store_hit;
			end
		end
	end

	// Response payload per side
	always_ff @(posedge iCLOCK) begin
		if (inst_hit) begin
			inst_rsp_data <= memory_data;
			inst_rsp_flags <= memory_flags;
		end
		if (data_hit || store_hit) begin
			data_rsp_data <= memory_data;
			data_rsp_flags <= memory_flags;
		end
	end

	// Nothing is presented to a side that is busy
	assign inst_rsp_valid = inst_valid_q && !inst_busy;
	assign data_rsp_valid = data_valid_q && !data_busy;

endmodule

`default_nettype wire

/* source/memory_pipe_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_pipe_arbiter
	import mem_arb_pkg::*;
#(
	parameter int QUEUE_DEPTH = 16,
	parameter int QUEUE_DEPTH_N = 4
) (
	input wire iCLOCK,
	input wire inRESET,
	// Data side, core to memory
	input wire data_req,
	output logic data_lock,
	input wire order_t data_order,
	input wire data_rw,
	input wire mmu_mode_t data_mmu_mode,
	input wire pdt_t data_pdt,
	input wire addr_t data_addr,
	input wire word_t data_data,
	// Data side, memory to core
	output logic data_rsp_valid,
	input wire data_busy,
	output line_t data_rsp_data,
	output mmu_flags_t data_rsp_flags,
	// Instruction side, core to memory
	input wire inst_req,
	output logic inst_lock,
	input wire mmu_mode_t inst_mmu_mode,
	input wire pdt_t inst_pdt,
	input wire addr_t inst_addr,
	// Instruction side, memory to core
	output logic inst_rsp_valid,
	input wire inst_busy,
	output line_t inst_rsp_data,
	output mmu_flags_t inst_rsp_flags,
	// Memory request bus
	output logic memory_req,
	input wire memory_lock,
	output logic memory_store_ack,
	output mmu_mode_t memory_mmu_mode,
	output pdt_t memory_pdt,
	output order_t memory_order,
	output logic memory_rw,
	output addr_t memory_addr,
	output word_t memory_data,
	// Memory response bus
	input wire memory_valid,
	output logic memory_busy,
	input wire memory_rsp_store_ack,
	input wire line_t memory_rsp_data,
	input wire mmu_flags_t memory_rsp_flags
);

	match_if u_match ();

	// Memory must stall if either side cannot take a response
	assign memory_busy = inst_busy || data_busy;

	req_arbiter u_req_arbiter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.data_req(data_req),
		.data_order(data_order),
		.data_rw(data_rw),
		.data_mmu_mode(data_mmu_mode),
		.data_pdt(data_pdt),
		.data_addr(data_addr),
		.data_data(data_data),
		.inst_req(inst_req),
		.inst_mmu_mode(inst_mmu_mode),
		.inst_pdt(inst_pdt),
		.inst_addr(inst_addr),
		.memory_lock(memory_lock),
		.data_lock(data_lock),
		.inst_lock(inst_lock),
		.memory_req(memory_req),
		.memory_store_ack(memory_store_ack),
		.memory_mmu_mode(memory_mmu_mode),
		.memory_pdt(memory_pdt),
		.memory_order(memory_order),
		.memory_rw(memory_rw),
		.memory_addr(memory_addr),
		.memory_data(memory_data),
		.match_wr(u_match.writer)
	);

	match_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.QUEUE_DEPTH_N(QUEUE_DEPTH_N)
	) u_match_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.match_q(u_match.queue)
	);

	rsp_router u_rsp_router (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.memory_valid(memory_valid),
		.memory_store_ack(memory_rsp_store_ack),
		.memory_data(memory_rsp_data),
		.memory_flags(memory_rsp_flags),
		.inst_busy(inst_busy),
		.data_busy(data_busy),
		.inst_rsp_valid(inst_rsp_valid),
		.inst_rsp_data(inst_rsp_data),
		.inst_rsp_flags(inst_rsp_flags),
		.data_rsp_valid(data_rsp_valid),
		.data_rsp_data(data_rsp_data),
		.data_rsp_flags(data_rsp_flags),
		.match_rd(u_match.reader)
	);

endmodule

`default_nettype wire

/* verif/mem_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_responder
	import mem_arb_pkg::*;
#(
	parameter int SEED = 32'h57286e70
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire memory_req,
	input wire memory_store_ack,
	input wire addr_t memory_addr,
	input wire data_lock,
	input wire inst_lock,
	input wire memory_busy,
	input wire hold,
	output logic memory_valid,
	output logic rsp_store_ack,
	output line_t rsp_data,
	output mmu_flags_t rsp_flags
);

	addr_t addr_q [$];
	logic store_q [$];
	logic loaded;
	int wait_cnt;
	integer seed;

	initial begin
		seed = SEED;
		loaded = 1'b0;
		wait_cnt = 0;
		memory_valid = 1'b0;
		rsp_store_ack = 1'b0;
		rsp_data = '0;
		rsp_flags = '0;
	end

	// The request register only loads when both side locks are not high together
	always @(negedge iCLOCK) begin
		if (!inRESET) begin
			loaded = 1'b0;
			addr_q.delete();
			store_q.delete();
		end else begin
			if (memory_req && loaded) begin
				addr_q.push_back(memory_addr);
				store_q.push_back(memory_store_ack);
			end
			loaded = !(data_lock && inst_lock);
		end
	end

	// One response per cycle, in request order, after a random gap
	always @(posedge iCLOCK) begin
		#2;
		memory_valid = 1'b0;
		rsp_store_ack = 1'b0;
		if (inRESET && addr_q.size() > 0 && !hold) begin
			if (wait_cnt > 0) begin
				wait_cnt--;
			end else if (!memory_busy) begin
				rsp_data = {addr_q[0] ^ 32'hA5A5_5A5A, addr_q[0]};
				rsp_flags = {24'h0, addr_q[0][3:0]};
				rsp_store_ack = store_q[0];
				memory_valid = 1'b1;
				void'(addr_q.pop_front());
				void'(store_q.pop_front());
				wait_cnt = $random(seed) & 3;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_memory_pipe_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_memory_pipe_arbiter
	import mem_arb_pkg::*;
();

	localparam int QUEUE_DEPTH = 16;
	localparam int QUEUE_DEPTH_N = 4;

	logic iCLOCK;
	logic inRESET;
	logic data_req, data_lock, data_rw, data_rsp_valid, data_busy;
	order_t data_order;
	mmu_mode_t data_mmu_mode;
	pdt_t data_pdt;
	addr_t data_addr;
	word_t data_data;
	line_t data_rsp_data;
	mmu_flags_t data_rsp_flags;
	logic inst_req, inst_lock, inst_rsp_valid, inst_busy;
	mmu_mode_t inst_mmu_mode;
	pdt_t inst_pdt;
	addr_t inst_addr;
	line_t inst_rsp_data;
	mmu_flags_t inst_rsp_flags;
	logic memory_req, memory_lock, memory_store_ack, memory_rw, memory_valid, memory_busy;
	mmu_mode_t memory_mmu_mode;
	pdt_t memory_pdt;
	order_t memory_order;
	addr_t memory_addr;
	word_t memory_data;
	logic memory_rsp_store_ack, hold, busy_rand;
	line_t memory_rsp_data;
	mmu_flags_t memory_rsp_flags;

	integer seed = 32'h57286e70;
	integer busy_seed = 32'h57286e70;
	int errors = 0;
	int tests = 0;
	string test_name = "none";
	line_t data_exp [$];
	line_t inst_exp [$];

	memory_pipe_arbiter #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.QUEUE_DEPTH_N(QUEUE_DEPTH_N)
	) u_memory_pipe_arbiter (.*);

	mem_responder u_mem (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .memory_req(memory_req),
		.memory_store_ack(memory_store_ack), .memory_addr(memory_addr),
		.data_lock(data_lock), .inst_lock(inst_lock), .memory_busy(memory_busy),
		.hold(hold), .memory_valid(memory_valid), .rsp_store_ack(memory_rsp_store_ack),
		.rsp_data(memory_rsp_data), .rsp_flags(memory_rsp_flags)
	);

	always #4 iCLOCK = !iCLOCK;

	function automatic line_t line_of(addr_t a);
		return {a ^ 32'hA5A5_5A5A, a};
	endfunction

	task automatic check(string what, logic [63:0] exp, logic [63:0] act);
		assert (exp === act) else begin
			errors++;
			$display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// Scoreboard samples at the falling edge where all signals are stable
	always @(negedge iCLOCK) begin
		line_t e;
		if (inRESET) begin
			if (data_rsp_valid) begin
				if (data_exp.size() == 0) begin
					errors++;
					$display("Unexpected data side response in test %s", test_name);
				end else begin
					e = data_exp.pop_front();
					check("data rsp", e, data_rsp_data);
					check("data flags", {24'h0, e[3:0]}, data_rsp_flags);
				end
			end
			if (inst_rsp_valid) begin
				if (inst_exp.size() == 0) begin
					errors++;
					$display("Unexpected instruction side response in test %s", test_name);
				end else begin
					e = inst_exp.pop_front();
					check("inst rsp", e, inst_rsp_data);
					check("inst flags", {24'h0, e[3:0]}, inst_rsp_flags);
				end
			end
			if (data_req && inst_req) begin
				check("inst_lock under data req", 1, inst_lock);
			end
			check("memory_busy", data_busy || inst_busy, memory_busy);
			if (data_req && !data_lock) begin
				data_exp.push_back(line_of(data_addr));
			end
			if (inst_req && !inst_lock) begin
				inst_exp.push_back(line_of(inst_addr));
			end
		end
	end

	// Random back-pressure on each side
	always @(posedge iCLOCK) begin
		#1;
		if (busy_rand) begin
			data_busy = ($random(busy_seed) & 3) == 0;
			inst_busy = ($random(busy_seed) & 3) == 0;
		end
	end

	// Holds requests until accepted and checks the registered bus
	task automatic issue(input logic dv, input logic drw, input addr_t da,
			input logic iv, input addr_t ia);
		logic d_pend, i_pend, d_acc, i_acc;
		int n;
		d_pend = dv;
		i_pend = iv;
		n = 0;
		data_rw = drw;
		data_addr = da;
		data_data = ~da;
		inst_addr = ia;
		while ((d_pend || i_pend) && n < 100) begin
			data_req = d_pend;
			inst_req = i_pend;
			@(negedge iCLOCK);
			d_acc = d_pend && !data_lock;
			i_acc = i_pend && !inst_lock;
			@(posedge iCLOCK);
			#1;
			data_req = 1'b0;
			inst_req = 1'b0;
			if (d_acc) begin
				check("req", 1, memory_req);
				check("data addr", da, memory_addr);
				check("data store_ack", drw, memory_store_ack);
				check("data order", 3, memory_order);
				check("data rw", drw, memory_rw);
				check("data word", data_data, memory_data);
				check("data mode", data_mmu_mode, memory_mmu_mode);
				check("data pdt", data_pdt, memory_pdt);
				d_pend = 1'b0;
			end else if (i_acc) begin
				check("fetch taken before data", 0, d_pend);
				check("req", 1, memory_req);
				check("fetch addr", ia, memory_addr);
				check("fetch order", FETCH_ORDER, memory_order);
				check("fetch rw", 0, memory_rw);
				check("fetch data", 0, memory_data);
				check("fetch store_ack", 0, memory_store_ack);
				check("fetch mode", inst_mmu_mode, memory_mmu_mode);
				check("fetch pdt", inst_pdt, memory_pdt);
				i_pend = 1'b0;
			end
			n++;
		end
		if (d_pend || i_pend) begin
			errors++;
			$display("Timeout: request never accepted in test %s", test_name);
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((data_exp.size() > 0 || inst_exp.size() > 0) && n < 500) begin
			@(posedge iCLOCK);
			n++;
		end
		#1;
		if (data_exp.size() > 0 || inst_exp.size() > 0) begin
			errors++;
			$display("Timeout: responses missing at end of test %s", test_name);
		end
	endtask

	task automatic finish_test(int start);
		tests++;
		$display("test %s: %0d errors", test_name, errors - start);
	endtask

	initial begin
		int start, n;
		addr_t a;
		logic rsp_taken;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		{data_req, data_rw, data_busy, inst_req, inst_busy, memory_lock} = '0;
		{hold, busy_rand} = '0;
		data_order = 2'd3;
		data_mmu_mode = 2'd1;
		data_pdt = 32'h1000;
		data_addr = '0;
		data_data = '0;
		inst_mmu_mode = 2'd2;
		inst_pdt = 32'h2000;
		inst_addr = '0;
		repeat (5) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;

		test_name = "reset";
		start = errors;
		@(negedge iCLOCK);
		check("memory_req", 0, memory_req);
		check("store_ack", 0, memory_store_ack);
		check("inst valid", 0, inst_rsp_valid);
		check("data valid", 0, data_rsp_valid);
		@(posedge iCLOCK);
		#1;
		finish_test(start);

		test_name = "priority";
		start = errors;
		issue(1, 0, 32'h0000_1230, 1, 32'h0000_4560);
		drain();
		finish_test(start);

		test_name = "fetch";
		start = errors;
		issue(0, 1, 0, 1, 32'h0000_8004);
		drain();
		finish_test(start);

		test_name = "store";
		start = errors;
		issue(1, 1, 32'h0000_2008, 0, 0);
		issue(1, 0, 32'h0000_200C, 0, 0);
		issue(0, 0, 0, 1, 32'h0000_3000);
		issue(1, 0, 32'h0000_2010, 0, 0);
		drain();
		finish_test(start);

		test_name = "ordering";
		start = errors;
		busy_rand = 1'b1;
		for (int i = 0; i < 40; i++) begin
			a = $random(seed);
			n = $random(seed) & 3;
			issue(n != 1, 1'b0, a & 32'hFFFF_FFF8, n != 0, ~a & 32'hFFFF_FFFC);
		end
		busy_rand = 1'b0;
		@(posedge iCLOCK);
		#1;
		data_busy = 1'b0;
		inst_busy = 1'b0;
		drain();
		finish_test(start);

		test_name = "lock";
		start = errors;
		memory_lock = 1'b1;
		data_req = 1'b1;
		inst_req = 1'b1;
		@(negedge iCLOCK);
		check("data_lock by memory", 1, data_lock);
		check("inst_lock by memory", 1, inst_lock);
		@(posedge iCLOCK);
		#1;
		check("memory_req under lock", 0, memory_req);
		data_req = 1'b0;
		inst_req = 1'b0;
		memory_lock = 1'b0;
		hold = 1'b1;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			issue(1, 0, 32'h0000_5000 + 8 * i, 0, 0);
		end
		data_req = 1'b1;
		inst_req = 1'b1;
		data_addr = 32'h0000_6000;
		inst_addr = 32'h0000_7000;
		repeat (3) begin
			@(negedge iCLOCK);
			check("data_lock when full", 1, data_lock);
			check("inst_lock when full", 1, inst_lock);
		end
		n = 0;
		rsp_taken = 1'b0;
		hold = 1'b0;
		while (data_lock && n < 100) begin
			// Memory answer in the cycle before the lock falls
			rsp_taken = memory_valid;
			@(negedge iCLOCK);
			n++;
		end
		if (data_lock) begin
			errors++;
			$display("Timeout: data lock never released after queue full");
		end
		check("response popped before release", 1, rsp_taken);
		@(posedge iCLOCK);
		#1;
		data_req = 1'b0;
		inst_req = 1'b0;
		drain();
		finish_test(start);

		$display("tests run %0d, checks failed %0d", tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/mem_arb_pkg.sv
source/match_if.sv
source/req_arbiter.sv
source/match_queue.sv
source/rsp_router.sv
source/memory_pipe_arbiter.sv
verif/mem_responder.sv
verif/tb_memory_pipe_arbiter.sv

/* Bender.yml */
package:
  name: memory_pipe_arbiter

sources:
  - source/mem_arb_pkg.sv
  - source/match_if.sv
  - source/req_arbiter.sv
  - source/match_queue.sv
  - source/rsp_router.sv
  - source/memory_pipe_arbiter.sv
  - target: test
    files:
      - verif/mem_responder.sv
      - verif/tb_memory_pipe_arbiter.sv
